//--- gpio_trace.txt
# cmd a b: W addr data, R addr expect, P pins, T tri_state_enable
# O pin_out n_oe, I gpio_int; all values hex, 16 pins
O 0000 ffff
I 0
R 00 00000000
R 04 00000000
R 08 00000000
R 0c 00000000
R 10 00000000
R 14 00000000
W 00 1234a5c3
R 00 0000a5c3
W 04 ffff00ff
R 04 000000ff
R 3c 00000000
W 08 ffffffff
R 08 00000000
O a5c3 ff00
T 000f
O a5c3 ff0f
W 0c 00000003
W 10 00000001
R 10 00000001
P 0001
I 1
P 0003
P 0001
W 14 00000000
R 14 00000003
W 14 00000001
I 1
R 14 00000002
W 14 00000002
I 0
P 0101
R 08 00000101
I 0
R 14 00000000

//--- verilog.f
gpio_pkg.sv
gpio_apb_decode.sv
gpio_pin_sync.sv
gpio_regs.sv
gpio_irq.sv
gpio_out_stage.sv
gpio_top.sv
tb_gpio.sv

//--- Makefile
# Verilator build and run for the apb gpio testbench
TOP = tb_gpio

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_gpio.sv
//------------------------------
// trace driven testbench for the apb gpio block
// run from the project root, reads gpio_trace.txt
//------------------------------
`timescale 1ns/1ps

module tb_gpio;
   localparam int PIN_COUNT = 16;

   logic                 pclk, arst_n;
   logic                 psel, penable, pwrite;
   logic [5:0]           paddr;
   logic [31:0]          pwdata, prdata;
   logic [PIN_COUNT-1:0] gpio_pin_in, tri_state_enable;
   logic [PIN_COUNT-1:0] gpio_pin_out, n_gpio_pin_oe;
   logic                 gpio_int;

   logic [7:0]  cmd_q[$];    // command letters
   logic [31:0] arg_a_q[$];  // first column
   logic [31:0] arg_b_q[$];  // second column, 0 if absent
   logic [31:0] lfsr;        // noise state
   logic [PIN_COUNT-1:0] shadow_q [0:15];  // expected control bank, by word address
   int          err_count;
   bit          loaded;      // trace in memory, watchdog may start

   gpio_top #(.PIN_COUNT(PIN_COUNT)) UUT
   (
      .pclk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
      .gpio_pin_in, .tri_state_enable, .gpio_pin_out, .n_gpio_pin_oe, .gpio_int
   );

   always #5 pclk = ~pclk;  // 100 MHz

   //------------------------------
   // helpers
   //------------------------------
   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_noise(output logic [15:0] bits);
      for (int i = 0; i < 16; i++)
      begin
         lfsr    = lfsr_step(lfsr);  // one step per bit
         bits[i] = lfsr[0];
      end
   endtask

   task automatic fail_now(input string msg);
      err_count++;
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic tick;
      @(posedge pclk);
      #1;  // drive and sample just after the edge
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: prdata got %h expected %h", $time, got, exp));
   endtask

   task automatic check_pins(input logic [PIN_COUNT-1:0] got_out, got_oe,
                             input logic [PIN_COUNT-1:0] exp_out, exp_oe);
      if (got_out !== exp_out)
         fail_now($sformatf("mismatch at %0t: gpio_pin_out got %h expected %h",
                            $time, got_out, exp_out));
      if (got_oe !== exp_oe)
         fail_now($sformatf("mismatch at %0t: n_gpio_pin_oe got %h expected %h",
                            $time, got_oe, exp_oe));
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: gpio_int got %b expected %b", $time, got, exp));
   endtask

   //------------------------------
   // apb transfers
   //------------------------------
   task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
      tick();
      psel   = 1'b1;  // setup
      pwrite = 1'b1;
      paddr  = addr;
      pwdata = data;
      tick();
      penable = 1'b1;  // access, lands at next edge
      tick();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [5:0] addr, input logic [31:0] exp);
      tick();
      psel   = 1'b1;
      pwrite = 1'b0;
      paddr  = addr;
      tick();
      penable = 1'b1;
      check_word(prdata, exp);  // captured at end of setup
      tick();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // whole control bank against the masked write data
   task automatic readback_ctrl;
      apb_read(6'h00, 32'(shadow_q[4'h0]));
      apb_read(6'h04, 32'(shadow_q[4'h1]));
      apb_read(6'h0c, 32'(shadow_q[4'h3]));
      apb_read(6'h10, 32'(shadow_q[4'h4]));
   endtask

   //------------------------------
   // main sequence
   //------------------------------
   initial
   begin
      int              fd;
      int              n;
      int              want;
      logic [7:0]      ch;
      logic [31:0]     a, b;
      logic [15:0]     noise;
      logic [8*80-1:0] rest;
      pclk = 1'b0;
      arst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      gpio_pin_in = '0;
      tri_state_enable = '0;
      lfsr = 32'haff2_616a;
      err_count = 0;
      foreach (shadow_q[k])
         shadow_q[k] = '0;  // reset value of the bank
      fd = $fopen("gpio_trace.txt", "r");
      if (fd == 0)
         fail_now("could not open gpio_trace.txt for reading");
      while ($fscanf(fd, " %c", ch) == 1)
      begin
         if (ch == "#")
            void'($fgets(rest, fd));  // column notes
         else
         begin
            b = '0;
            want = (ch inside {"W", "R", "O"}) ? 2 : 1;
            n = $fscanf(fd, "%h", a);
            if (want == 2)
               n += $fscanf(fd, "%h", b);
            if (n != want)
               fail_now($sformatf("trace line for command %c is missing a value", ch));
            cmd_q.push_back(ch);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
         end
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (8) @(posedge pclk);  // reset held 8 cycles
      #1 arst_n = 1'b1;
      foreach (cmd_q[i])
      begin
         a = arg_a_q[i];
         b = arg_b_q[i];
         case (cmd_q[i])
            "W":
            begin
               if (a[5:0] == 6'h00)
               begin
                  take_noise(noise);
                  b = b ^ {noise, 16'h0000};  // junk above the 16 pins
               end
               if (a[5:2] inside {4'h0, 4'h1, 4'h3, 4'h4})
                  shadow_q[a[5:2]] = b[PIN_COUNT-1:0];  // only the pin bits stick
               apb_write(a[5:0], b);
            end
            "R": apb_read(a[5:0], b);
            "P":
            begin
               tick();
               gpio_pin_in = a[PIN_COUNT-1:0];
               repeat (6) tick();  // sync, edge and status
            end
            "T":
            begin
               tick();
               tri_state_enable = a[PIN_COUNT-1:0];
            end
            "O":
            begin
               tick();
               check_pins(gpio_pin_out, n_gpio_pin_oe, a[PIN_COUNT-1:0], b[PIN_COUNT-1:0]);
            end
            "I":
            begin
               tick();
               check_irq(gpio_int, a[0]);
            end
            default: fail_now($sformatf("unknown command %c in trace line %0d", cmd_q[i], i));
         endcase
      end
      readback_ctrl();
      if (err_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // watchdog, 20 cycles per command plus slack
   initial
   begin
      wait (loaded);
      repeat (cmd_q.size() * 20 + 100) @(posedge pclk);
      fail_now("timeout: the trace did not finish in time");
   end

endmodule

//--- gpio_top.sv
//------------------------------
// apb gpio top level
// PIN_COUNT up to 32, default 16
//------------------------------
`timescale 1ns/1ps

module gpio_top
#(
   parameter int PIN_COUNT = 16
)
(
   input  logic                 pclk,
   input  logic                 arst_n,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [5:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   input  logic [PIN_COUNT-1:0] gpio_pin_in,
   input  logic [PIN_COUNT-1:0] tri_state_enable,
   output logic [PIN_COUNT-1:0] gpio_pin_out,
   output logic [PIN_COUNT-1:0] n_gpio_pin_oe,
   output logic                 gpio_int
);
   import gpio_pkg::*;

   bus_req_t    bus_req;  // one-cycle request
   pin_sample_t pins;     // synced level and edges
   ctrl_regs_t  ctrl;
   logic [31:0] rd_mux;
   logic [31:0] status;

   //------------------------------
   // input side
   //------------------------------
   gpio_apb_decode u_decode
   (
      .pclk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
      .bus_req (bus_req)
   );

   gpio_pin_sync #(.PIN_COUNT(PIN_COUNT)) u_pin_sync
   (
      .pclk, .arst_n,
      .pin_in  (gpio_pin_in),
      .pins    (pins)
   );

   //------------------------------
   // processing
   //------------------------------
   gpio_regs #(.PIN_COUNT(PIN_COUNT)) u_regs
   (
      .pclk, .arst_n, .bus_req, .pins, .status, .ctrl, .rd_mux
   );

   gpio_irq #(.PIN_COUNT(PIN_COUNT)) u_irq
   (
      .pclk, .arst_n, .bus_req, .pins, .ctrl, .status,
      .irq     (gpio_int)  // straight to the pin
   );

   //------------------------------
   // output side
   //------------------------------
   gpio_out_stage #(.PIN_COUNT(PIN_COUNT)) u_out_stage
   (
      .pclk, .arst_n,
      .op      (bus_req.op),
      .rd_mux, .ctrl, .tri_state_enable,
      .prdata, .gpio_pin_out, .n_gpio_pin_oe
   );

endmodule

//--- gpio_out_stage.sv
//------------------------------
// apb read data register and pin drive
//------------------------------
`timescale 1ns/1ps

module gpio_out_stage
#(
   parameter int PIN_COUNT = 16
)
(
   input  logic                 pclk,
   input  logic                 arst_n,
   input  gpio_pkg::apb_op_e    op,
   input  logic [31:0]          rd_mux,
   input  gpio_pkg::ctrl_regs_t ctrl,
   input  logic [PIN_COUNT-1:0] tri_state_enable,  // test override
   output logic [31:0]          prdata,
   output logic [PIN_COUNT-1:0] gpio_pin_out,
   output logic [PIN_COUNT-1:0] n_gpio_pin_oe      // active low enable
);
   import gpio_pkg::*;

   localparam logic [MAX_PINS-1:0] PIN_MASK = {MAX_PINS{1'b1}} >> (MAX_PINS - PIN_COUNT);

   // loads at the end of setup, held through access
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         prdata <= '0;
      else if (op == OP_READ)
         prdata <= rd_mux & PIN_MASK;  // zero above the pins
   end

   assign gpio_pin_out  = ctrl.data_out[PIN_COUNT-1:0];
   assign n_gpio_pin_oe = ~(ctrl.dir[PIN_COUNT-1:0] & ~tri_state_enable);

   a_pin_count: assert property (@(posedge pclk)
      (PIN_COUNT >= 1) && (PIN_COUNT <= MAX_PINS))
      else $error("PIN_COUNT out of range");

   // read data may not move during the access phase
   a_prdata_stable: assert property (@(posedge pclk) disable iff (!arst_n)
      (op == OP_READ) |=> ##1 $stable(prdata))
      else $error("prdata changed during read access");

endmodule

//--- gpio_irq.sv
//------------------------------
// interrupt status and the irq line
//------------------------------
`timescale 1ns/1ps

module gpio_irq
#(
   parameter int PIN_COUNT = 16
)
(
   input  logic                  pclk,
   input  logic                  arst_n,
   input  gpio_pkg::bus_req_t    bus_req,
   input  gpio_pkg::pin_sample_t pins,
   input  gpio_pkg::ctrl_regs_t  ctrl,
   output logic [31:0]           status,
   output logic                  irq
);
   import gpio_pkg::*;

   logic [PIN_COUNT-1:0] status_q;
   logic [PIN_COUNT-1:0] en, pol;
   logic [PIN_COUNT-1:0] edge_hit;  // enabled edge this cycle
   logic [PIN_COUNT-1:0] clr_mask;  // write-1-to-clear bits

   assign en  = ctrl.int_en[PIN_COUNT-1:0];
   assign pol = ctrl.int_pol[PIN_COUNT-1:0];

   // polarity picks rise or fall per pin
   assign edge_hit = en & ((pol & pins.rise[PIN_COUNT-1:0]) |
                           (~pol & pins.fall[PIN_COUNT-1:0]));

   assign clr_mask = (bus_req.op == OP_WRITE && bus_req.regsel == REG_INT_STATUS)
                     ? bus_req.wdata[PIN_COUNT-1:0] : '0;

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         status_q <= '0;
      else
         status_q <= (status_q & ~clr_mask) | edge_hit;  // set beats clear
   end

   always_comb
   begin
      status = '0;
      status[PIN_COUNT-1:0] = status_q;
   end

   assign irq = |(status_q & en);  // masked status ORed down

   a_pin_count: assert property (@(posedge pclk)
      (PIN_COUNT >= 1) && (PIN_COUNT <= MAX_PINS))
      else $error("PIN_COUNT out of range");

   a_status_range: assert property (@(posedge pclk) disable iff (!arst_n)
      (status >> PIN_COUNT) == '0)
      else $error("status bit set above PIN_COUNT");

endmodule

//--- gpio_regs.sv
//------------------------------
// control register bank and read mux
// status bits live in the interrupt unit
//------------------------------
`timescale 1ns/1ps

module gpio_regs
#(
   parameter int PIN_COUNT = 16
)
(
   input  logic                  pclk,
   input  logic                  arst_n,
   input  gpio_pkg::bus_req_t    bus_req,
   input  gpio_pkg::pin_sample_t pins,
   input  logic [31:0]           status,  // from irq unit
   output gpio_pkg::ctrl_regs_t  ctrl,
   output logic [31:0]           rd_mux   // combinational read value
);
   import gpio_pkg::*;

   logic [PIN_COUNT-1:0] data_out_q;
   logic [PIN_COUNT-1:0] dir_q;       // 1 = drive the pin
   logic [PIN_COUNT-1:0] int_en_q;
   logic [PIN_COUNT-1:0] int_pol_q;   // 1 = rising edge
   logic [PIN_COUNT-1:0] wdata_pins;  // write data cut to pin width
   logic                 wr;

   assign wr         = (bus_req.op == OP_WRITE);
   assign wdata_pins = bus_req.wdata[PIN_COUNT-1:0];

   //------------------------------
   // register writes
   //------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         data_out_q <= '0;
         dir_q      <= '0;  // all pins input
         int_en_q   <= '0;
         int_pol_q  <= '0;
      end
      else if (wr)
      begin
         case (bus_req.regsel)
            REG_DATA_OUT: data_out_q <= wdata_pins;
            REG_DIR:      dir_q      <= wdata_pins;
            REG_INT_EN:   int_en_q   <= wdata_pins;
            REG_INT_POL:  int_pol_q  <= wdata_pins;
            default:
            begin
               // pin in, status and holes are not held here
            end
         endcase
      end
   end

   // widen to the struct, upper bits stay zero
   always_comb
   begin
      ctrl = '0;
      ctrl.data_out[PIN_COUNT-1:0] = data_out_q;
      ctrl.dir[PIN_COUNT-1:0]      = dir_q;
      ctrl.int_en[PIN_COUNT-1:0]   = int_en_q;
      ctrl.int_pol[PIN_COUNT-1:0]  = int_pol_q;
   end

   //------------------------------
   // read mux
   //------------------------------
   always_comb
   begin
      case (bus_req.regsel)
         REG_DATA_OUT:   rd_mux = ctrl.data_out;
         REG_DIR:        rd_mux = ctrl.dir;
         REG_PIN_IN:     rd_mux = pins.level;  // synchronised level
         REG_INT_EN:     rd_mux = ctrl.int_en;
         REG_INT_POL:    rd_mux = ctrl.int_pol;
         REG_INT_STATUS: rd_mux = status;
         default:        rd_mux = '0;          // unmapped reads zero
      endcase
   end

   //------------------------------
   // checks
   //------------------------------
   a_pin_count: assert property (@(posedge pclk)
      (PIN_COUNT >= 1) && (PIN_COUNT <= MAX_PINS))
      else $error("PIN_COUNT out of range");

endmodule

//--- gpio_pin_sync.sv
//------------------------------
// pin input synchroniser with edge pulses
//------------------------------
`timescale 1ns/1ps

module gpio_pin_sync
#(
   parameter int PIN_COUNT = 16
)
(
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic [PIN_COUNT-1:0]  pin_in,  // async pins
   output gpio_pkg::pin_sample_t pins
);
   import gpio_pkg::*;

   logic [PIN_COUNT-1:0] sync1_q, sync2_q;  // two-flop synchroniser
   logic [PIN_COUNT-1:0] prev_q;            // last synchronised sample
   logic [PIN_COUNT-1:0] rise_q, fall_q;

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
         prev_q  <= '0;
         rise_q  <= '0;
         fall_q  <= '0;
      end
      else
      begin
         sync1_q <= pin_in;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
         rise_q  <= sync2_q & ~prev_q;  // pulse one edge after level
         fall_q  <= ~sync2_q & prev_q;
      end
   end

   // zero-extend into the wide struct
   always_comb
   begin
      pins = '0;
      pins.level[PIN_COUNT-1:0] = sync2_q;
      pins.rise[PIN_COUNT-1:0]  = rise_q;
      pins.fall[PIN_COUNT-1:0]  = fall_q;
   end

   a_pin_count: assert property (@(posedge pclk)
      (PIN_COUNT >= 1) && (PIN_COUNT <= MAX_PINS))
      else $error("PIN_COUNT out of range");

endmodule

//--- gpio_apb_decode.sv
//------------------------------
// apb slave front end, zero wait states
// gives one-cycle read and write requests
//------------------------------
`timescale 1ns/1ps

module gpio_apb_decode
(
   input  logic               pclk,     // only for the protocol check
   input  logic               arst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [5:0]         paddr,
   input  logic [31:0]        pwdata,
   output gpio_pkg::bus_req_t bus_req
);
   import gpio_pkg::*;

   reg_addr_e regsel;  // decoded word address

   // word address onto the register map
   always_comb
   begin
      case (paddr[5:2])
         4'h0:    regsel = REG_DATA_OUT;
         4'h1:    regsel = REG_DIR;
         4'h2:    regsel = REG_PIN_IN;
         4'h3:    regsel = REG_INT_EN;
         4'h4:    regsel = REG_INT_POL;
         4'h5:    regsel = REG_INT_STATUS;
         default: regsel = REG_NONE;
      endcase
   end

   always_comb
   begin
      bus_req.op = OP_IDLE;
      if (psel && penable && pwrite)
         bus_req.op = OP_WRITE;  // write lands at end of access
      else if (psel && !penable && !pwrite)
         bus_req.op = OP_READ;   // read sampled in setup
      bus_req.regsel = regsel;
      bus_req.wdata  = pwdata;
   end

   // access phase always follows a selected setup phase
   a_enable_needs_sel: assert property (@(posedge pclk) disable iff (!arst_n)
      penable |-> psel && $past(psel))
      else $error("penable without psel");

endmodule

//--- gpio_pkg.sv
//------------------------------
// shared types for the apb gpio block
// modules import it inside their body
//------------------------------
package gpio_pkg;

   localparam int MAX_PINS = 32;  // widest pin count the structs carry

   //------------------------------
   // register map
   //------------------------------
   // encoding follows paddr[5:2]
   typedef enum logic [3:0]
   {
      REG_DATA_OUT   = 4'h0,  // 0x00
      REG_DIR        = 4'h1,  // 0x04 1 = output
      REG_PIN_IN     = 4'h2,  // 0x08 read only
      REG_INT_EN     = 4'h3,  // 0x0c
      REG_INT_POL    = 4'h4,  // 0x10 1 = rising
      REG_INT_STATUS = 4'h5,  // 0x14 write 1 to clear
      REG_NONE       = 4'hf   // any unmapped slot
   } reg_addr_e;

   // bus operation seen by the register side
   typedef enum logic [1:0]
   {
      OP_IDLE  = 2'd0,
      OP_READ  = 2'd1,  // setup phase of a read
      OP_WRITE = 2'd2   // access phase of a write
   } apb_op_e;

   //------------------------------
   // structs
   //------------------------------
   typedef struct packed
   {
      apb_op_e     op;
      reg_addr_e   regsel;  // decoded register
      logic [31:0] wdata;
   } bus_req_t;  // 38 bits

   // only the low PIN_COUNT bits of each field carry pins
   typedef struct packed
   {
      logic [MAX_PINS-1:0] level;  // synchronised pin level
      logic [MAX_PINS-1:0] rise;   // one cycle pulse
      logic [MAX_PINS-1:0] fall;   // one cycle pulse
   } pin_sample_t;  // 96 bits

   typedef struct packed
   {
      logic [MAX_PINS-1:0] data_out;
      logic [MAX_PINS-1:0] dir;
      logic [MAX_PINS-1:0] int_en;
      logic [MAX_PINS-1:0] int_pol;
   } ctrl_regs_t;  // 128 bits

endpackage
